// ==== verilog.f ====
+incdir+hdl
hdl/rv_dec_pkg.sv
hdl/dec_if.sv
hdl/inst_decoder.sv
hdl/imm_gen.sv
hdl/operand_bypass.sv
hdl/id_issue.sv
hdl/id_stage.sv
testbench/tb_id_stage.sv

// ==== Bender.yml ====
package:
  name: rv_id_stage

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rv_dec_pkg.sv
      - hdl/dec_if.sv
      - hdl/inst_decoder.sv
      - hdl/imm_gen.sv
      - hdl/operand_bypass.sv
      - hdl/id_issue.sv
      - hdl/id_stage.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/tb_id_stage.sv

// ==== testbench/tb_id_stage.sv ====
`default_nettype none

`include "rv_dec_cfg.svh"

module tb_id_stage;
  timeunit 1ns;
  timeprecision 100ps;

  import rv_dec_pkg::*;

  localparam int CREDITS  = `RV_ID_CREDITS;
  localparam int NUM_INST = 400;
  localparam int MAX_CYC  = 4000;

  // expected contents of the ID/EX register for one instruction
  typedef struct packed {
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    reg_idx_t    rd;
    csr_idx_t    csr;
    logic [4:0]  alu;
    logic [3:0]  exc;
    logic [3:0]  mem;
    logic [2:0]  csrop;
    trap_t       trap;
    xlen_t       imm;
    xlen_t       d1;
    xlen_t       d2;
  } pred_t;

  logic     clk_i;
  logic     rst_i;
  inst_u    inst_i;
  logic     inst_valid_i;
  logic     inst_ready_o;
  trap_t    trap_i;
  reg_idx_t rs1_idx_o;
  reg_idx_t rs2_idx_o;
  xlen_t    rs1_data_i;
  xlen_t    rs2_data_i;
  reg_idx_t mem_rd_addr_i;
  xlen_t    mem_rd_data_i;
  xlen_t    ex_rd_data_i;
  logic     ex_credit_i;
  logic     ex_valid_o;
  reg_idx_t ex_rd_idx_o;
  xlen_t    ex_rs1_data_o;
  xlen_t    ex_rs2_data_o;
  xlen_t    ex_imm_o;
  csr_idx_t ex_csr_idx_o;
  alu_op_e  ex_alu_op_o;
  exc_op_e  ex_exc_op_o;
  mem_op_e  ex_mem_op_o;
  csr_op_e  ex_csr_op_o;
  trap_t    ex_trap_o;

  logic [31:0] lfsr;
  logic [31:0] rf_salt;
  pred_t       pend[$];
  int          m_credits = CREDITS;
  logic        m_ex_valid = 1'b0;
  reg_idx_t    m_ex_rd = '0;
  logic        m_ex_load = 1'b0;
  logic        took = 1'b0;
  reg_idx_t    last_rd = '0;
  int          dut_out = 0;
  int          n_checks = 0;
  int          n_errors = 0;
  int          n_issued = 0;
  int          n_stalls = 0;

  id_stage UUT (.*);

  // register file read, x0 reads as zero
  function automatic xlen_t rf_value(input reg_idx_t idx, input logic [31:0] salt);
    if (idx == '0) begin
      return '0;
    end
    return {salt ^ {27'd0, idx}, 27'h2B3C4D5, idx};
  endfunction

  assign rs1_data_i = rf_value(rs1_idx_o, rf_salt);
  assign rs2_data_i = rf_value(rs2_idx_o, rf_salt);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    int          k;
    r = '0;
    for (k = 0; k < n; k++) begin
      lfsr = lfsr_next(lfsr);
      r    = {r[62:0], lfsr[0]};
    end
    return r;
  endfunction

  task automatic check_value(input string name, input logic [63:0] act, input logic [63:0] want);
    n_checks++;
    if (act !== want) begin
      n_errors++;
      $display("Mismatch at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, act, want);
    end
  endtask

  function automatic logic [4:0] int_alu(input logic [2:0] f3, input logic alt, input logic rr);
    case (f3)
      3'b000: return (rr && alt) ? ALU_SUB : ALU_ADD;
      3'b001: return ALU_SLL;
      3'b010: return ALU_SLT;
      3'b011: return ALU_SLTU;
      3'b100: return ALU_XOR;
      3'b101: return alt ? ALU_SRA : ALU_SRL;
      3'b110: return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  function automatic logic [4:0] word_alu(input logic [2:0] f3, input logic alt, input logic rr);
    case (f3)
      3'b000: return (rr && alt) ? ALU_SUB : ALU_ADD;
      3'b001: return ALU_SLLW;
      3'b101: return alt ? ALU_SRAW : ALU_SRLW;
      default: return ALU_NOP;
    endcase
  endfunction

  function automatic logic [4:0] branch_alu(input logic [2:0] f3);
    case (f3)
      3'b000: return ALU_BEQ;
      3'b001: return ALU_BNE;
      3'b100: return ALU_BLT;
      3'b101: return ALU_BGE;
      3'b110: return ALU_BLTU;
      3'b111: return ALU_BGEU;
      default: return ALU_NOP;
    endcase
  endfunction

  // reference decode from the RV64I encoding tables
  function automatic pred_t predict(input logic [31:0] w, input trap_t tr);
    pred_t      p;
    logic [2:0] f3;
    logic       alt;
    logic       sys0;
    logic       bad;
    logic       u1;
    logic       u2;
    logic       ud;
    xlen_t      sx;
    p    = '0;
    f3   = w[14:12];
    alt  = w[30];
    sys0 = w[6:0] == OPC_SYSTEM && f3 == 3'b000;
    sx   = {`RV_XLEN{w[31]}};
    bad  = 1'b0;
    u1   = 1'b0;
    u2   = 1'b0;
    ud   = 1'b0;
    case (w[6:0])
      OPC_LUI, OPC_AUIPC: begin
        ud    = 1'b1;
        p.exc = (w[6:0] == OPC_LUI) ? EXC_LUI : EXC_AUIPC;
        p.alu = ALU_ADD;
        p.imm = {sx[63:32], w[31:12], 12'h000};
      end
      OPC_JAL: begin
        ud    = 1'b1;
        p.exc = EXC_JAL;
        p.alu = ALU_ADD;
        p.imm = {sx[63:21], w[31], w[19:12], w[20], w[30:21], 1'b0};
      end
      OPC_JALR, OPC_LOAD, OPC_OPIMM, OPC_OPIMM32: begin
        u1    = 1'b1;
        ud    = 1'b1;
        p.imm = {sx[63:12], w[31:20]};
        p.alu = ALU_ADD;
        p.exc = EXC_JALR;
        if (w[6:0] == OPC_LOAD) begin
          p.exc = EXC_LOAD;
          p.mem = (f3 == 3'b111) ? MEM_NONE : MEM_LB + {1'b0, f3};
        end else if (w[6:0] == OPC_OPIMM) begin
          p.exc = EXC_OPIMM;
          p.alu = int_alu(f3, alt, 1'b0);
        end else if (w[6:0] == OPC_OPIMM32) begin
          p.exc = EXC_OPIMM32;
          p.alu = word_alu(f3, alt, 1'b0);
        end
      end
      OPC_BRANCH: begin
        u1    = 1'b1;
        u2    = 1'b1;
        p.exc = EXC_BRANCH;
        p.alu = branch_alu(f3);
        p.imm = {sx[63:13], w[31], w[7], w[30:25], w[11:8], 1'b0};
      end
      OPC_STORE: begin
        u1    = 1'b1;
        u2    = 1'b1;
        p.exc = EXC_STORE;
        p.alu = ALU_ADD;
        p.mem = f3[2] ? MEM_NONE : MEM_SB + {1'b0, f3};
        p.imm = {sx[63:12], w[31:25], w[11:7]};
      end
      OPC_OP, OPC_OP32: begin
        u1    = 1'b1;
        u2    = 1'b1;
        ud    = 1'b1;
        bad   = w[31:25] == 7'b0000001;
        p.exc = (w[6:0] == OPC_OP) ? EXC_OP : EXC_OP32;
        p.alu = (w[6:0] == OPC_OP) ? int_alu(f3, alt, 1'b1) : word_alu(f3, alt, 1'b1);
      end
      OPC_MISCMEM: p.exc = EXC_FENCE;
      OPC_SYSTEM: begin
        p.imm = {sx[63:12], w[31:20]};
        if (f3[1:0] != 2'b00) begin
          u1    = !f3[2];
          ud    = 1'b1;
          p.exc = EXC_CSR;
          p.alu = ALU_ADD;
          p.csr = w[31:20];
          if (f3[1:0] == 2'b01) begin
            p.csrop = CSR_WRITE;
          end else if (w[19:15] == 5'd0) begin
            p.csrop = CSR_READ;
          end else begin
            p.csrop = (f3[1:0] == 2'b10) ? CSR_SET : CSR_CLEAR;
          end
        end else if (sys0 && w[31:20] == 12'h001) begin
          p.exc = EXC_EBREAK;
        end
      end
      default: bad = 1'b1;
    endcase
    if (bad) begin
      p.alu = ALU_NOP;
      p.exc = EXC_NONE;
    end
    p.rs1 = (u1 && !bad) ? w[19:15] : '0;
    p.rs2 = (u2 && !bad) ? w[24:20] : '0;
    p.rd  = (ud && !bad) ? w[11:7] : '0;
    p.trap                   = tr;
    p.trap[`RV_TRAP_MRET]    = sys0 && w[31:20] == 12'h302;
    p.trap[`RV_TRAP_EBREAK]  = sys0 && w[31:20] == 12'h001;
    p.trap[`RV_TRAP_ECALL_M] = sys0 && w[31:20] == 12'h000;
    p.trap[`RV_TRAP_ILLEGAL] = bad;
    return p;
  endfunction

  // EX result first, then MEM, then the register file
  function automatic xlen_t fwd_value(input reg_idx_t idx);
    if (idx == '0) begin
      return rf_value(idx, rf_salt);
    end
    if (m_ex_valid && m_ex_rd == idx) begin
      return ex_rd_data_i;
    end
    if (mem_rd_addr_i == idx) begin
      return mem_rd_data_i;
    end
    return rf_value(idx, rf_salt);
  endfunction

  // mostly legal RV64I, small register range so hazards show up
  function automatic logic [31:0] gen_inst();
    logic [3:0]  cls;
    logic [6:0]  opc;
    logic [6:0]  f7;
    logic [4:0]  rs2;
    logic [4:0]  rs1;
    logic [2:0]  f3;
    logic [4:0]  rd;
    cls = 4'(rand_bits(4));
    f7  = 7'(rand_bits(7));
    rs2 = 5'(rand_bits(5));
    rs1 = 5'(rand_bits(3));
    f3  = 3'(rand_bits(3));
    rd  = 5'(rand_bits(3));
    opc = OPC_MISCMEM;
    case (cls)
      4'd0, 4'd1, 4'd2: begin
        opc = (cls == 4'd0) ? OPC_LUI : ((cls == 4'd1) ? OPC_AUIPC : OPC_JAL);
        rs1 = 5'(rand_bits(5));
      end
      4'd3: opc = OPC_JALR;
      4'd4, 4'd7: begin
        opc      = (cls == 4'd4) ? OPC_BRANCH : OPC_STORE;
        rs2[4:3] = 2'b00;
      end
      4'd5, 4'd6: opc = OPC_LOAD;
      4'd8: opc = OPC_OPIMM;
      4'd9: opc = OPC_OPIMM32;
      4'd10, 4'd11: begin
        opc      = (cls == 4'd10) ? OPC_OP : OPC_OP32;
        f7       = {1'b0, f7[5], 5'b00000};
        rs2[4:3] = 2'b00;
      end
      4'd12: begin
        opc = OPC_SYSTEM;
        if (f3[1:0] == 2'b00) begin
          f3[0] = 1'b1;
        end
      end
      4'd13: begin
        // ecall, ebreak, mret and wfi, which is a plain no-op here
        opc = OPC_SYSTEM;
        f3  = 3'b000;
        rs1 = '0;
        rd  = '0;
        case (2'(rand_bits(2)))
          2'd0: {f7, rs2} = 12'h000;
          2'd1: {f7, rs2} = 12'h001;
          2'd2: {f7, rs2} = 12'h302;
          default: {f7, rs2} = 12'h105;
        endcase
      end
      4'd14: opc = OPC_MISCMEM;
      default: begin
        if (rand_bits(1) != 0) begin
          opc = (rand_bits(1) != 0) ? OPC_OP : OPC_OP32;
          f7  = 7'b0000001;
        end else begin
          case (2'(rand_bits(2)))
            2'd0: opc = 7'h00;
            2'd1: opc = 7'h53;
            2'd2: opc = 7'h2F;
            default: opc = 7'h7F;
          endcase
        end
      end
    endcase
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  task automatic compare_issue(input pred_t want);
    check_value("ex_rd_idx_o", 64'(ex_rd_idx_o), 64'(want.rd));
    check_value("ex_rs1_data_o", ex_rs1_data_o, want.d1);
    check_value("ex_rs2_data_o", ex_rs2_data_o, want.d2);
    check_value("ex_imm_o", ex_imm_o, want.imm);
    check_value("ex_csr_idx_o", 64'(ex_csr_idx_o), 64'(want.csr));
    check_value("ex_alu_op_o", 64'(ex_alu_op_o), 64'(want.alu));
    check_value("ex_exc_op_o", 64'(ex_exc_op_o), 64'(want.exc));
    check_value("ex_mem_op_o", 64'(ex_mem_op_o), 64'(want.mem));
    check_value("ex_csr_op_o", 64'(ex_csr_op_o), 64'(want.csrop));
    check_value("ex_trap_o", 64'(ex_trap_o), 64'(want.trap));
  endtask

  // per cycle side inputs, credits only for issues still held by EX
  task automatic drive_side(input logic withhold);
    logic give;
    logic pick_last;
    give      = rand_bits(1) != 0;
    pick_last = rand_bits(1) != 0;
    mem_rd_addr_i <= pick_last ? last_rd : reg_idx_t'(rand_bits(3));
    mem_rd_data_i <= rand_bits(64);
    ex_rd_data_i  <= rand_bits(64);
    rf_salt       <= 32'(rand_bits(32));
    ex_credit_i   <= give && !withhold && m_credits < CREDITS;
  endtask

  // fetch keeps its instruction until it is taken
  task automatic drive_fetch(input logic more);
    logic [31:0] w;
    if (!more) begin
      inst_valid_i <= 1'b0;
    end else if (!inst_valid_i || took) begin
      if (rand_bits(3) == 0) begin
        inst_valid_i <= 1'b0;
      end else begin
        w = gen_inst();
        inst_valid_i <= 1'b1;
        inst_i       <= w;
        trap_i       <= trap_t'(rand_bits(16));
      end
    end
  endtask

  // sample mid cycle, then step the model state to the next cycle
  always @(negedge clk_i) begin : monitor
    pred_t cur;
    pred_t want;
    logic  hazard;
    logic  exp_ready;
    logic  acc;
    if (!rst_i) begin
      cur = predict(inst_i, trap_i);
      check_value("rs1_idx_o", 64'(rs1_idx_o), 64'(cur.rs1));
      check_value("rs2_idx_o", 64'(rs2_idx_o), 64'(cur.rs2));
      check_value("ex_valid_o", 64'(ex_valid_o), 64'(m_ex_valid));
      if (ex_valid_o) begin
        dut_out++;
        if (pend.size() == 0) begin
          n_errors++;
          $display("Error at %0t ns: ex_valid_o high with no instruction pending", $time);
        end else begin
          want = pend.pop_front();
          compare_issue(want);
        end
      end
      if (ex_credit_i) begin
        dut_out--;
      end
      if (dut_out > CREDITS) begin
        n_errors++;
        $display("Error at %0t ns: %0d issues outstanding with %0d credits", $time, dut_out,
                 CREDITS);
      end
      hazard = m_ex_valid && m_ex_load && m_ex_rd != '0 &&
               (m_ex_rd == cur.rs1 || m_ex_rd == cur.rs2);
      exp_ready = m_credits > 0 && !hazard;
      check_value("inst_ready_o", 64'(inst_ready_o), 64'(exp_ready));
      acc = inst_valid_i && exp_ready;
      if (hazard && inst_valid_i) begin
        n_stalls++;
      end
      if (acc) begin
        cur.d1 = fwd_value(cur.rs1);
        cur.d2 = fwd_value(cur.rs2);
        pend.push_back(cur);
        n_issued++;
        last_rd   = cur.rd;
        m_ex_rd   = cur.rd;
        m_ex_load = cur.exc == EXC_LOAD;
      end
      m_credits  = m_credits - int'(acc) + int'(ex_credit_i);
      m_ex_valid = acc;
      took       = acc;
    end
  end

  initial begin : stimulus
    int cyc;
    int drain;
    lfsr          = 32'd38;
    rst_i         = 1'b1;
    inst_valid_i  = 1'b0;
    inst_i        = '0;
    trap_i        = '0;
    mem_rd_addr_i = '0;
    mem_rd_data_i = '0;
    ex_rd_data_i  = '0;
    ex_credit_i   = 1'b0;
    rf_salt       = '0;
    repeat (16) @(posedge clk_i);
    rst_i <= 1'b0;
    cyc = 0;
    // no credits at the start and for a window later on
    while (n_issued < NUM_INST && cyc < MAX_CYC) begin
      @(posedge clk_i);
      drive_side(cyc < 12 || (cyc >= 300 && cyc < 340));
      drive_fetch(1'b1);
      cyc++;
    end
    if (n_issued < NUM_INST) begin
      n_errors++;
      $display("Timeout: only %0d of %0d instructions issued", n_issued, NUM_INST);
    end else begin
      drain = 0;
      while ((pend.size() != 0 || m_credits != CREDITS) && drain < 200) begin
        @(posedge clk_i);
        drive_side(1'b0);
        drive_fetch(1'b0);
        drain++;
      end
      if (pend.size() != 0 || m_credits != CREDITS) begin
        n_errors++;
        $display("Timeout: %0d instructions never reached the EX outputs", pend.size());
      end
    end
    $display("checks %0d, errors %0d, issued %0d, stalls %0d", n_checks, n_errors, n_issued,
             n_stalls);
    if (n_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== hdl/id_stage.sv ====
`default_nettype none

module id_stage (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  rv_dec_pkg::inst_u    inst_i,
  input  logic                 inst_valid_i,
  output logic                 inst_ready_o,
  input  rv_dec_pkg::trap_t    trap_i,
  output rv_dec_pkg::reg_idx_t rs1_idx_o,
  output rv_dec_pkg::reg_idx_t rs2_idx_o,
  input  rv_dec_pkg::xlen_t    rs1_data_i,
  input  rv_dec_pkg::xlen_t    rs2_data_i,
  input  rv_dec_pkg::reg_idx_t mem_rd_addr_i,
  input  rv_dec_pkg::xlen_t    mem_rd_data_i,
  input  rv_dec_pkg::xlen_t    ex_rd_data_i,
  input  logic                 ex_credit_i,
  output logic                 ex_valid_o,
  output rv_dec_pkg::reg_idx_t ex_rd_idx_o,
  output rv_dec_pkg::xlen_t    ex_rs1_data_o,
  output rv_dec_pkg::xlen_t    ex_rs2_data_o,
  output rv_dec_pkg::xlen_t    ex_imm_o,
  output rv_dec_pkg::csr_idx_t ex_csr_idx_o,
  output rv_dec_pkg::alu_op_e  ex_alu_op_o,
  output rv_dec_pkg::exc_op_e  ex_exc_op_o,
  output rv_dec_pkg::mem_op_e  ex_mem_op_o,
  output rv_dec_pkg::csr_op_e  ex_csr_op_o,
  output rv_dec_pkg::trap_t    ex_trap_o
);
  import rv_dec_pkg::*;

  xlen_t imm;
  xlen_t rs1_fwd;
  xlen_t rs2_fwd;
  logic  load_use;

  dec_if dec_bus ();

  inst_decoder u_decoder (
    .inst_i (inst_i),
    .trap_i (trap_i),
    .dec    (dec_bus)
  );

  imm_gen u_imm_gen (
    .inst_i (inst_i),
    .imm_o  (imm)
  );

  // register file is read with the gated indices
  assign rs1_idx_o = dec_bus.rs1_idx;
  assign rs2_idx_o = dec_bus.rs2_idx;

  operand_bypass u_bypass (
    .dec           (dec_bus),
    .rs1_data_i    (rs1_data_i),
    .rs2_data_i    (rs2_data_i),
    .mem_rd_data_i (mem_rd_data_i),
    .ex_rd_data_i  (ex_rd_data_i),
    .mem_rd_addr_i (mem_rd_addr_i),
    .ex_rd_idx_i   (ex_rd_idx_o),
    .ex_valid_i    (ex_valid_o),
    .ex_exc_op_i   (ex_exc_op_o),
    .rs1_fwd_o     (rs1_fwd),
    .rs2_fwd_o     (rs2_fwd),
    .load_use_o    (load_use)
  );

  id_issue u_issue (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .inst_valid_i  (inst_valid_i),
    .inst_ready_o  (inst_ready_o),
    .ex_credit_i   (ex_credit_i),
    .load_use_i    (load_use),
    .dec           (dec_bus),
    .imm_i         (imm),
    .rs1_fwd_i     (rs1_fwd),
    .rs2_fwd_i     (rs2_fwd),
    .ex_valid_o    (ex_valid_o),
    .ex_rd_idx_o   (ex_rd_idx_o),
    .ex_rs1_data_o (ex_rs1_data_o),
    .ex_rs2_data_o (ex_rs2_data_o),
    .ex_imm_o      (ex_imm_o),
    .ex_csr_idx_o  (ex_csr_idx_o),
    .ex_alu_op_o   (ex_alu_op_o),
    .ex_exc_op_o   (ex_exc_op_o),
    .ex_mem_op_o   (ex_mem_op_o),
    .ex_csr_op_o   (ex_csr_op_o),
    .ex_trap_o     (ex_trap_o)
  );

endmodule

`default_nettype wire

// ==== hdl/id_issue.sv ====
`default_nettype none

`include "rv_dec_cfg.svh"

module id_issue (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 inst_valid_i,
  output logic                 inst_ready_o,
  input  logic                 ex_credit_i,
  input  logic                 load_use_i,
  dec_if.sink                  dec,
  input  rv_dec_pkg::xlen_t    imm_i,
  input  rv_dec_pkg::xlen_t    rs1_fwd_i,
  input  rv_dec_pkg::xlen_t    rs2_fwd_i,
  output logic                 ex_valid_o,
  output rv_dec_pkg::reg_idx_t ex_rd_idx_o,
  output rv_dec_pkg::xlen_t    ex_rs1_data_o,
  output rv_dec_pkg::xlen_t    ex_rs2_data_o,
  output rv_dec_pkg::xlen_t    ex_imm_o,
  output rv_dec_pkg::csr_idx_t ex_csr_idx_o,
  output rv_dec_pkg::alu_op_e  ex_alu_op_o,
  output rv_dec_pkg::exc_op_e  ex_exc_op_o,
  output rv_dec_pkg::mem_op_e  ex_mem_op_o,
  output rv_dec_pkg::csr_op_e  ex_csr_op_o,
  output rv_dec_pkg::trap_t    ex_trap_o
);

  localparam int CW = $clog2(`RV_ID_CREDITS + 1);

  logic [CW-1:0] credits_q;
  logic          accept;

  assign inst_ready_o = credits_q != '0 && !load_use_i;
  assign accept       = inst_valid_i && inst_ready_o;

  // one credit per free slot in EX, a spend and a return cancel
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      credits_q  <= CW'(`RV_ID_CREDITS);
      ex_valid_o <= 1'b0;
    end else begin
      ex_valid_o <= accept;
      if (accept && !ex_credit_i) begin
        credits_q <= credits_q - 1'b1;
      end else if (!accept && ex_credit_i) begin
        credits_q <= credits_q + 1'b1;
      end
    end
  end

  // payload only moves on a handshake
  always_ff @(posedge clk_i) begin
    if (accept) begin
      ex_rd_idx_o   <= dec.rd_idx;
      ex_rs1_data_o <= rs1_fwd_i;
      ex_rs2_data_o <= rs2_fwd_i;
      ex_imm_o      <= imm_i;
      ex_csr_idx_o  <= dec.csr_idx;
      ex_alu_op_o   <= dec.alu_op;
      ex_exc_op_o   <= dec.exc_op;
      ex_mem_op_o   <= dec.mem_op;
      ex_csr_op_o   <= dec.csr_op;
      ex_trap_o     <= dec.trap;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/operand_bypass.sv ====
`default_nettype none

module operand_bypass (
  dec_if.sink                  dec,
  input  rv_dec_pkg::xlen_t    rs1_data_i,
  input  rv_dec_pkg::xlen_t    rs2_data_i,
  input  rv_dec_pkg::xlen_t    mem_rd_data_i,
  input  rv_dec_pkg::xlen_t    ex_rd_data_i,
  input  rv_dec_pkg::reg_idx_t mem_rd_addr_i,
  input  rv_dec_pkg::reg_idx_t ex_rd_idx_i,
  input  logic                 ex_valid_i,
  input  rv_dec_pkg::exc_op_e  ex_exc_op_i,
  output rv_dec_pkg::xlen_t    rs1_fwd_o,
  output rv_dec_pkg::xlen_t    rs2_fwd_o,
  output logic                 load_use_o
);
  import rv_dec_pkg::*;

  logic ex_hit1;
  logic ex_hit2;
  logic mem_hit1;
  logic mem_hit2;

  // x0 never matches since its writes are dropped
  assign ex_hit1  = ex_valid_i && ex_rd_idx_i != '0 && ex_rd_idx_i == dec.rs1_idx;
  assign ex_hit2  = ex_valid_i && ex_rd_idx_i != '0 && ex_rd_idx_i == dec.rs2_idx;
  assign mem_hit1 = mem_rd_addr_i != '0 && mem_rd_addr_i == dec.rs1_idx;
  assign mem_hit2 = mem_rd_addr_i != '0 && mem_rd_addr_i == dec.rs2_idx;

  // younger result wins
  assign rs1_fwd_o = ex_hit1 ? ex_rd_data_i : (mem_hit1 ? mem_rd_data_i : rs1_data_i);
  assign rs2_fwd_o = ex_hit2 ? ex_rd_data_i : (mem_hit2 ? mem_rd_data_i : rs2_data_i);

  // load data is not ready until MEM, so hold one cycle
  assign load_use_o = ex_valid_i && ex_exc_op_i == EXC_LOAD && (ex_hit1 || ex_hit2);

endmodule

`default_nettype wire

// ==== hdl/imm_gen.sv ====
`default_nettype none

`include "rv_dec_cfg.svh"

module imm_gen (
  input  rv_dec_pkg::inst_u inst_i,
  output rv_dec_pkg::xlen_t imm_o
);
  import rv_dec_pkg::*;

  logic sgn;

  // instruction bit 31 is the sign in every format
  assign sgn = inst_i.i.imm12[11];

  always_comb begin
    case (inst_i.r.opcode)
      OPC_LOAD, OPC_OPIMM, OPC_OPIMM32, OPC_JALR, OPC_SYSTEM:
        imm_o = {{(`RV_XLEN-12){sgn}}, inst_i.i.imm12};
      OPC_STORE:
        imm_o = {{(`RV_XLEN-12){sgn}}, inst_i.r.funct7, inst_i.r.rd};
      OPC_BRANCH:
        imm_o = {{(`RV_XLEN-12){sgn}}, inst_i.r.rd[0], inst_i.r.funct7[5:0],
                 inst_i.r.rd[4:1], 1'b0};
      OPC_LUI, OPC_AUIPC:
        imm_o = {{(`RV_XLEN-32){sgn}}, inst_i.i.imm12, inst_i.i.rs1, inst_i.i.funct3, 12'b0};
      // imm[19:12] sits in the rs1/funct3 slots
      OPC_JAL:
        imm_o = {{(`RV_XLEN-20){sgn}}, inst_i.i.rs1, inst_i.i.funct3, inst_i.i.imm12[0],
                 inst_i.i.imm12[10:1], 1'b0};
      default: imm_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/inst_decoder.sv ====
`default_nettype none

`include "rv_dec_cfg.svh"

module inst_decoder (
  input  rv_dec_pkg::inst_u inst_i,
  input  rv_dec_pkg::trap_t trap_i,
  dec_if.dec                dec
);
  import rv_dec_pkg::*;

  opcode_e    opc;
  logic [2:0] f3;
  logic [6:0] f7;
  logic       class_ok;
  logic       m_ext;
  logic       illegal;
  logic       use_rs1;
  logic       use_rs2;
  logic       use_rd;
  logic       is_csr;
  logic       is_ecall;
  logic       is_ebreak;
  logic       is_mret;
  alu_op_e    alu_op;
  exc_op_e    exc_op;

  assign opc = inst_i.r.opcode;
  assign f3  = inst_i.r.funct3;
  assign f7  = inst_i.r.funct7;

  // mul/div share OP and OP32 with funct7 0000001, not supported here
  assign m_ext   = (opc == OPC_OP || opc == OPC_OP32) && f7 == 7'b0000001;
  assign illegal = !class_ok || m_ext;

  assign is_csr    = opc == OPC_SYSTEM && f3[1:0] != 2'b00;
  assign is_ecall  = opc == OPC_SYSTEM && f3 == 3'b000 && inst_i.i.imm12 == 12'h000;
  assign is_ebreak = opc == OPC_SYSTEM && f3 == 3'b000 && inst_i.i.imm12 == 12'h001;
  assign is_mret   = opc == OPC_SYSTEM && f3 == 3'b000 && inst_i.i.imm12 == 12'h302;

  // operand usage per format
  always_comb begin
    class_ok = 1'b1;
    use_rs1  = 1'b0;
    use_rs2  = 1'b0;
    use_rd   = 1'b0;
    case (opc)
      OPC_OP, OPC_OP32: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        use_rd  = 1'b1;
      end
      OPC_LOAD, OPC_OPIMM, OPC_OPIMM32, OPC_JALR: begin
        use_rs1 = 1'b1;
        use_rd  = 1'b1;
      end
      OPC_STORE, OPC_BRANCH: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
      end
      OPC_LUI, OPC_AUIPC, OPC_JAL: use_rd = 1'b1;
      // the immediate csr forms carry uimm in the rs1 field
      OPC_SYSTEM: begin
        use_rs1 = is_csr && !f3[2];
        use_rd  = is_csr;
      end
      OPC_MISCMEM: class_ok = 1'b1;
      default: class_ok = 1'b0;
    endcase
  end

  assign dec.rs1_idx = (use_rs1 && !illegal) ? inst_i.r.rs1 : '0;
  assign dec.rs2_idx = (use_rs2 && !illegal) ? inst_i.r.rs2 : '0;
  assign dec.rd_idx  = (use_rd && !illegal) ? inst_i.r.rd : '0;
  assign dec.csr_idx = is_csr ? inst_i.i.imm12 : '0;

  // funct7 bit 5 picks sub and arithmetic shifts
  always_comb begin
    alu_op = ALU_NOP;
    case (opc)
      OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_LOAD, OPC_STORE: alu_op = ALU_ADD;
      OPC_SYSTEM: alu_op = is_csr ? ALU_ADD : ALU_NOP;
      OPC_BRANCH: begin
        case (f3)
          3'b000: alu_op = ALU_BEQ;
          3'b001: alu_op = ALU_BNE;
          3'b100: alu_op = ALU_BLT;
          3'b101: alu_op = ALU_BGE;
          3'b110: alu_op = ALU_BLTU;
          3'b111: alu_op = ALU_BGEU;
          default: alu_op = ALU_NOP;
        endcase
      end
      OPC_OP, OPC_OPIMM: begin
        case (f3)
          3'b000: alu_op = (opc == OPC_OP && f7[5]) ? ALU_SUB : ALU_ADD;
          3'b001: alu_op = ALU_SLL;
          3'b010: alu_op = ALU_SLT;
          3'b011: alu_op = ALU_SLTU;
          3'b100: alu_op = ALU_XOR;
          3'b101: alu_op = f7[5] ? ALU_SRA : ALU_SRL;
          3'b110: alu_op = ALU_OR;
          default: alu_op = ALU_AND;
        endcase
      end
      OPC_OP32, OPC_OPIMM32: begin
        case (f3)
          3'b000: alu_op = (opc == OPC_OP32 && f7[5]) ? ALU_SUB : ALU_ADD;
          3'b001: alu_op = ALU_SLLW;
          3'b101: alu_op = f7[5] ? ALU_SRAW : ALU_SRLW;
          default: alu_op = ALU_NOP;
        endcase
      end
      default: alu_op = ALU_NOP;
    endcase
  end

  always_comb begin
    exc_op     = EXC_NONE;
    dec.mem_op = MEM_NONE;
    case (opc)
      OPC_LUI: exc_op = EXC_LUI;
      OPC_AUIPC: exc_op = EXC_AUIPC;
      OPC_JAL: exc_op = EXC_JAL;
      OPC_JALR: exc_op = EXC_JALR;
      OPC_BRANCH: exc_op = EXC_BRANCH;
      OPC_OPIMM: exc_op = EXC_OPIMM;
      OPC_OPIMM32: exc_op = EXC_OPIMM32;
      OPC_OP: exc_op = EXC_OP;
      OPC_OP32: exc_op = EXC_OP32;
      OPC_MISCMEM: exc_op = EXC_FENCE;
      OPC_SYSTEM: exc_op = is_csr ? EXC_CSR : (is_ebreak ? EXC_EBREAK : EXC_NONE);
      OPC_LOAD: begin
        exc_op = EXC_LOAD;
        case (f3)
          3'b000: dec.mem_op = MEM_LB;
          3'b001: dec.mem_op = MEM_LH;
          3'b010: dec.mem_op = MEM_LW;
          3'b011: dec.mem_op = MEM_LD;
          3'b100: dec.mem_op = MEM_LBU;
          3'b101: dec.mem_op = MEM_LHU;
          3'b110: dec.mem_op = MEM_LWU;
          default: dec.mem_op = MEM_NONE;
        endcase
      end
      OPC_STORE: begin
        exc_op = EXC_STORE;
        case (f3)
          3'b000: dec.mem_op = MEM_SB;
          3'b001: dec.mem_op = MEM_SH;
          3'b010: dec.mem_op = MEM_SW;
          3'b011: dec.mem_op = MEM_SD;
          default: dec.mem_op = MEM_NONE;
        endcase
      end
      default: exc_op = EXC_NONE;
    endcase
  end

  assign dec.alu_op = illegal ? ALU_NOP : alu_op;
  assign dec.exc_op = illegal ? EXC_NONE : exc_op;

  // set/clear from x0 only reads the csr
  always_comb begin
    dec.csr_op = CSR_NONE;
    if (is_csr) begin
      case (f3[1:0])
        2'b01: dec.csr_op = CSR_WRITE;
        2'b10: dec.csr_op = (inst_i.r.rs1 == '0) ? CSR_READ : CSR_SET;
        default: dec.csr_op = (inst_i.r.rs1 == '0) ? CSR_READ : CSR_CLEAR;
      endcase
    end
  end

  // decode owns four trap bits, the rest come from fetch
  always_comb begin
    dec.trap                   = trap_i;
    dec.trap[`RV_TRAP_MRET]    = is_mret;
    dec.trap[`RV_TRAP_EBREAK]  = is_ebreak;
    dec.trap[`RV_TRAP_ECALL_M] = is_ecall;
    dec.trap[`RV_TRAP_ILLEGAL] = illegal;
  end

endmodule

`default_nettype wire

// ==== hdl/dec_if.sv ====
`default_nettype none

interface dec_if;
  import rv_dec_pkg::*;

  // register indices, already zeroed when not used
  reg_idx_t rs1_idx;
  reg_idx_t rs2_idx;
  reg_idx_t rd_idx;
  csr_idx_t csr_idx;
  alu_op_e  alu_op;
  exc_op_e  exc_op;
  mem_op_e  mem_op;
  csr_op_e  csr_op;
  trap_t    trap;

  modport dec (
    output rs1_idx, rs2_idx, rd_idx, csr_idx, alu_op, exc_op, mem_op, csr_op, trap
  );

  modport sink (
    input rs1_idx, rs2_idx, rd_idx, csr_idx, alu_op, exc_op, mem_op, csr_op, trap
  );

endinterface

`default_nettype wire

// ==== hdl/rv_dec_pkg.sv ====
`default_nettype none

`include "rv_dec_cfg.svh"

package rv_dec_pkg;

  typedef logic [`RV_XLEN-1:0]       xlen_t;
  typedef logic [`RV_REG_ADDR_W-1:0] reg_idx_t;
  typedef logic [`RV_CSR_ADDR_W-1:0] csr_idx_t;
  typedef logic [`RV_TRAP_LEN-1:0]   trap_t;

  // major opcodes of the rv64i base set
  typedef enum logic [6:0] {
    OPC_LOAD    = 7'b0000011,
    OPC_MISCMEM = 7'b0001111,
    OPC_OPIMM   = 7'b0010011,
    OPC_AUIPC   = 7'b0010111,
    OPC_OPIMM32 = 7'b0011011,
    OPC_STORE   = 7'b0100011,
    OPC_OP      = 7'b0110011,
    OPC_LUI     = 7'b0110111,
    OPC_OP32    = 7'b0111011,
    OPC_BRANCH  = 7'b1100011,
    OPC_JALR    = 7'b1100111,
    OPC_JAL     = 7'b1101111,
    OPC_SYSTEM  = 7'b1110011
  } opcode_e;

  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    opcode_e    opcode;
  } inst_r_t;

  // imm12 doubles as the csr address and the system sub-code
  typedef struct packed {
    logic [11:0] imm12;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    opcode_e     opcode;
  } inst_i_t;

  typedef union packed {
    inst_r_t r;
    inst_i_t i;
  } inst_u;

  typedef enum logic [4:0] {
    ALU_NOP, ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLLW, ALU_SRLW, ALU_SRAW, ALU_SLT, ALU_SLTU, ALU_BEQ, ALU_BNE, ALU_BLT,
    ALU_BGE, ALU_BLTU, ALU_BGEU
  } alu_op_e;

  typedef enum logic [3:0] {
    EXC_NONE, EXC_LUI, EXC_AUIPC, EXC_JAL, EXC_JALR, EXC_BRANCH, EXC_LOAD, EXC_STORE,
    EXC_OPIMM, EXC_OPIMM32, EXC_OP, EXC_OP32, EXC_CSR, EXC_EBREAK, EXC_FENCE
  } exc_op_e;

  typedef enum logic [3:0] {
    MEM_NONE, MEM_LB, MEM_LH, MEM_LW, MEM_LD, MEM_LBU, MEM_LHU, MEM_LWU,
    MEM_SB, MEM_SH, MEM_SW, MEM_SD
  } mem_op_e;

  typedef enum logic [2:0] {
    CSR_NONE, CSR_READ, CSR_WRITE, CSR_SET, CSR_CLEAR
  } csr_op_e;

endpackage

`default_nettype wire

// ==== hdl/rv_dec_cfg.svh ====
`ifndef RV_DEC_CFG_SVH
`define RV_DEC_CFG_SVH

// datapath and instruction word
`define RV_XLEN 64
`define RV_INST_LEN 32

// register file and csr address widths
`define RV_REG_ADDR_W 5
`define RV_CSR_ADDR_W 12

// trap vector and the bits set in decode
`define RV_TRAP_LEN 16
`define RV_TRAP_MRET 0
`define RV_TRAP_EBREAK 1
`define RV_TRAP_ECALL_M 2
`define RV_TRAP_ILLEGAL 3

// input slots of the execute stage, 1 to 7
`define RV_ID_CREDITS 2

`endif
